// ==== hdl/wi23_settings.svh ====
`ifndef WI23_SETTINGS_SVH
`define WI23_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

// One fetched instruction word
`define WI23_IMEM_WIDTH 32

// One integer or FP register
`define WI23_REGFILE_WIDTH 32

// Register select for 32 registers per file
`define WI23_REGFILE_DEPTH 5

`endif

// ==== hdl/wi23_defs.sv ====
`default_nettype none

`include "wi23_settings.svh"

package wi23_defs;

    //////////////////////////////////////////////////////////////////////
    // Width types
    //////////////////////////////////////////////////////////////////////

    typedef logic [`WI23_IMEM_WIDTH-1:0]    inst_t;
    typedef logic [`WI23_REGFILE_WIDTH-1:0] word_t;
    typedef logic [`WI23_REGFILE_DEPTH-1:0] reg_sel_t;

    // Major opcode in inst[31:26]
    typedef logic [5:0] opcode_t;

    //////////////////////////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////////////////////////

    localparam opcode_t OP_ADD   = 6'd0;
    localparam opcode_t OP_ADDI  = 6'd1;
    localparam opcode_t OP_ORI   = 6'd2;
    localparam opcode_t OP_LD    = 6'd3;
    localparam opcode_t OP_ST    = 6'd4;
    localparam opcode_t OP_J     = 6'd5;
    localparam opcode_t OP_JAL   = 6'd6;
    // Floating-point group
    localparam opcode_t OP_FADD  = 6'd16;
    localparam opcode_t OP_FLD   = 6'd17;
    localparam opcode_t OP_FST   = 6'd18;
    localparam opcode_t OP_FCVTI = 6'd19;
    localparam opcode_t OP_FMOVI = 6'd20;
    localparam opcode_t OP_NOP   = 6'd63;

    // Instruction formats for inst_fmt
    localparam logic [1:0] FMT_R = 2'd0;
    localparam logic [1:0] FMT_I = 2'd1;
    localparam logic [1:0] FMT_J = 2'd2;

    // Jump kinds for j_type
    localparam logic [1:0] J_NONE = 2'd0;
    localparam logic [1:0] J_JUMP = 2'd1;
    localparam logic [1:0] J_LINK = 2'd2;

    //////////////////////////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [1:0] inst_fmt;
        logic [1:0] j_type;
        logic       xtend_sel;      // 1 zero-extends the immediate
        logic       reg_write;
        logic       fp_reg_write;
        logic       fp_inst;
        logic [1:0] fp_int_cvt_reg; // bit 0 takes fs from the integer file
        logic       mem_read;
        logic       mem_write;
    } ctrl_t;

    // One writeback port
    typedef struct packed {
        logic     en;
        reg_sel_t sel;
        word_t    data;
    } wb_t;

    typedef struct packed {
        word_t reg1;
        word_t reg2;
        word_t imm;
        word_t ofs;
        word_t fp_reg1;
        word_t fp_reg2;
    } operands_t;

endpackage

`default_nettype wire

// ==== hdl/rf.sv ====
`default_nettype none

`include "wi23_settings.svh"

module rf #(
    parameter bit has_zero_reg = 1'b1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                write,
    input  wi23_defs::reg_sel_t writeregsel,
    input  wi23_defs::word_t    writedata,
    input  wi23_defs::reg_sel_t read1regsel,
    input  wi23_defs::reg_sel_t read2regsel,
    output wi23_defs::word_t    read1data,
    output wi23_defs::word_t    read2data,
    output logic                err
);
    import wi23_defs::*;

    localparam int NUM_REGS = 1 << `WI23_REGFILE_DEPTH;

    word_t regs [NUM_REGS];

    logic wr_zero;
    logic rd1_zero;
    logic rd2_zero;

    // Register 0 is only special in the integer file
    assign wr_zero  = has_zero_reg && (writeregsel == '0);
    assign rd1_zero = has_zero_reg && (read1regsel == '0);
    assign rd2_zero = has_zero_reg && (read2regsel == '0);

    //////////////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write && !wr_zero) begin
            regs[writeregsel] <= writedata;
        end
    end

    // Writing the hardwired register is flagged and dropped
    assign err = write && wr_zero;

    //////////////////////////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////////////////////////

    assign read1data = rd1_zero ? '0 : regs[read1regsel];
    assign read2data = rd2_zero ? '0 : regs[read2regsel];

    // Writeback enable must be a clean level
    a_write_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(write)
    ) else $error("rf: write enable is unknown");

endmodule

`default_nettype wire

// ==== hdl/inst_ctrl.sv ====
`default_nettype none

module inst_ctrl (
    input  wi23_defs::inst_t inst,
    input  wi23_defs::wb_t   int_wb,
    input  wi23_defs::wb_t   fp_wb,
    output wi23_defs::ctrl_t ctrl,
    output logic             bypass_reg1,
    output logic             bypass_reg2,
    output logic             fp_bypass_reg1,
    output logic             fp_bypass_reg2,
    output logic             illegal
);
    import wi23_defs::*;

    opcode_t  opcode;
    reg_sel_t rs_sel;
    reg_sel_t rt_sel;

    assign opcode = inst[31:26];
    assign rs_sel = inst[25:21];
    assign rt_sel = inst[20:16];

    //////////////////////////////////////////////////////////////////////
    // Opcode table
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl    = '0;
        illegal = 1'b0;
        case (opcode)
            OP_ADD: begin
                ctrl.inst_fmt  = FMT_R;
                ctrl.reg_write = 1'b1;
            end
            OP_ADDI: begin
                ctrl.inst_fmt  = FMT_I;
                ctrl.reg_write = 1'b1;
            end
            OP_ORI: begin
                // Logical immediate is zero-extended
                ctrl.inst_fmt  = FMT_I;
                ctrl.xtend_sel = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_LD: begin
                ctrl.inst_fmt  = FMT_I;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            OP_ST: begin
                ctrl.inst_fmt  = FMT_I;
                ctrl.mem_write = 1'b1;
            end
            OP_J: begin
                ctrl.inst_fmt = FMT_J;
                ctrl.j_type   = J_JUMP;
            end
            OP_JAL: begin
                // Link register written by writeback
                ctrl.inst_fmt  = FMT_J;
                ctrl.j_type    = J_LINK;
                ctrl.reg_write = 1'b1;
            end
            OP_FADD: begin
                ctrl.inst_fmt     = FMT_R;
                ctrl.fp_inst      = 1'b1;
                ctrl.fp_reg_write = 1'b1;
            end
            OP_FLD: begin
                // Fd travels in rt
                ctrl.inst_fmt     = FMT_I;
                ctrl.fp_inst      = 1'b1;
                ctrl.fp_reg_write = 1'b1;
                ctrl.mem_read     = 1'b1;
            end
            OP_FST: begin
                ctrl.inst_fmt  = FMT_I;
                ctrl.fp_inst   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OP_FCVTI, OP_FMOVI: begin
                // Source comes from the integer file
                ctrl.inst_fmt       = FMT_R;
                ctrl.fp_inst        = 1'b1;
                ctrl.fp_reg_write   = 1'b1;
                ctrl.fp_int_cvt_reg = 2'b01;
            end
            OP_NOP: begin
                // All fields stay cleared
                ctrl = '0;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Bypass detection
    //////////////////////////////////////////////////////////////////////

    // Hardwired integer register 0 is never forwarded
    assign bypass_reg1 = int_wb.en && (int_wb.sel != '0) && (int_wb.sel == rs_sel);
    assign bypass_reg2 = int_wb.en && (int_wb.sel != '0) && (int_wb.sel == rt_sel);

    assign fp_bypass_reg1 = fp_wb.en && (fp_wb.sel == rs_sel);
    assign fp_bypass_reg2 = fp_wb.en && (fp_wb.sel == rt_sel);

endmodule

`default_nettype wire

// ==== hdl/decode.sv ====
`default_nettype none

`include "wi23_settings.svh"

module decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  wi23_defs::inst_t     inst,
    input  wi23_defs::ctrl_t     ctrl,
    input  wi23_defs::wb_t       int_wb,
    input  wi23_defs::wb_t       fp_wb,
    input  logic                 bypass_reg1,
    input  logic                 bypass_reg2,
    input  logic                 fp_bypass_reg1,
    input  logic                 fp_bypass_reg2,
    output wi23_defs::operands_t operands,
    output logic                 rf_err
);
    import wi23_defs::*;

    reg_sel_t rs_sel;
    reg_sel_t rt_sel;

    word_t reg1_raw;
    word_t reg2_raw;
    word_t fp_reg1_raw;
    word_t fp_reg2_raw;

    word_t dec_reg1;
    word_t dec_reg2;
    word_t dec_fp_reg1;
    word_t dec_fp_reg2;

    word_t imm_sext;
    word_t imm_zext;

    logic int_err;
    logic mem_access;

    // Both files are addressed by the same rs/rt fields
    assign rs_sel = inst[25:21];
    assign rt_sel = inst[20:16];

    //////////////////////////////////////////////////////////////////////
    // Integer register file
    //////////////////////////////////////////////////////////////////////

    rf #(.has_zero_reg(1'b1)) iRF (
        .clk         (clk),
        .rst_n       (rst_n),
        .write       (int_wb.en),
        .writeregsel (int_wb.sel),
        .writedata   (int_wb.data),
        .read1regsel (rs_sel),
        .read2regsel (rt_sel),
        .read1data   (reg1_raw),
        .read2data   (reg2_raw),
        .err         (int_err)
    );

    assign dec_reg1 = bypass_reg1 ? int_wb.data : reg1_raw;
    assign dec_reg2 = bypass_reg2 ? int_wb.data : reg2_raw;

    //////////////////////////////////////////////////////////////////////
    // FP register file
    //////////////////////////////////////////////////////////////////////

    // No hardwired register here, so err never rises
    rf #(.has_zero_reg(1'b0)) iFPRF (
        .clk         (clk),
        .rst_n       (rst_n),
        .write       (fp_wb.en),
        .writeregsel (fp_wb.sel),
        .writedata   (fp_wb.data),
        .read1regsel (rs_sel),
        .read2regsel (rt_sel),
        .read1data   (fp_reg1_raw),
        .read2data   (fp_reg2_raw),
        .err         ()
    );

    assign dec_fp_reg1 = fp_bypass_reg1 ? fp_wb.data : fp_reg1_raw;
    assign dec_fp_reg2 = fp_bypass_reg2 ? fp_wb.data : fp_reg2_raw;

    assign rf_err = int_err;

    // Immediate and jump offset
    assign imm_sext = {{(`WI23_REGFILE_WIDTH-16){inst[15]}}, inst[15:0]};
    assign imm_zext = {{(`WI23_REGFILE_WIDTH-16){1'b0}}, inst[15:0]};

    assign operands.imm = ctrl.xtend_sel ? imm_zext : imm_sext;
    assign operands.ofs = {{(`WI23_REGFILE_WIDTH-26){inst[25]}}, inst[25:0]};

    //////////////////////////////////////////////////////////////////////
    // Operand steering
    //////////////////////////////////////////////////////////////////////

    assign mem_access = ctrl.mem_read | ctrl.mem_write;

    // FP loads and stores carry Fd in reg2
    assign operands.reg1 = dec_reg1;
    assign operands.reg2 = (ctrl.fp_inst && mem_access) ? dec_fp_reg2 : dec_reg2;

    // Convert and move read their source from the integer file
    assign operands.fp_reg1 = (ctrl.fp_inst && ctrl.fp_int_cvt_reg[0]) ? dec_reg1
                                                                        : dec_fp_reg1;
    assign operands.fp_reg2 = dec_fp_reg2;

    a_int_bypass: assert property (
        @(posedge clk) disable iff (!rst_n) (bypass_reg1 || bypass_reg2) |-> int_wb.en
    ) else $error("decode: integer bypass without writeback");

    a_fp_bypass: assert property (
        @(posedge clk) disable iff (!rst_n) (fp_bypass_reg1 || fp_bypass_reg2) |-> fp_wb.en
    ) else $error("decode: FP bypass without writeback");

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`default_nettype none

module decode_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  wi23_defs::inst_t     inst,
    input  wi23_defs::wb_t       int_wb,
    input  wi23_defs::wb_t       fp_wb,
    output wi23_defs::ctrl_t     ctrl,
    output wi23_defs::operands_t operands,
    output logic                 decode_err
);

    logic bypass_reg1;
    logic bypass_reg2;
    logic fp_bypass_reg1;
    logic fp_bypass_reg2;
    logic illegal;
    logic rf_err;

    // Opcode decode and forwarding detection
    inst_ctrl i_ctrl (
        .inst           (inst),
        .int_wb         (int_wb),
        .fp_wb          (fp_wb),
        .ctrl           (ctrl),
        .bypass_reg1    (bypass_reg1),
        .bypass_reg2    (bypass_reg2),
        .fp_bypass_reg1 (fp_bypass_reg1),
        .fp_bypass_reg2 (fp_bypass_reg2),
        .illegal        (illegal)
    );

    // Register files and operand datapath
    decode i_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst           (inst),
        .ctrl           (ctrl),
        .int_wb         (int_wb),
        .fp_wb          (fp_wb),
        .bypass_reg1    (bypass_reg1),
        .bypass_reg2    (bypass_reg2),
        .fp_bypass_reg1 (fp_bypass_reg1),
        .fp_bypass_reg2 (fp_bypass_reg2),
        .operands       (operands),
        .rf_err         (rf_err)
    );

    // Either source flags the instruction
    assign decode_err = illegal | rf_err;

endmodule

`default_nettype wire

// ==== test/decode_stage_tb.sv ====
`default_nettype none

module decode_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import wi23_defs::*;

    localparam int RESET_CYCLES  = 10;
    localparam int RAND_CYCLES   = 64;
    // Drive cycles of all six tests plus one closing cycle per test
    localparam int TEST_CYCLES   = 32 + (RAND_CYCLES + 32) + 32 + RAND_CYCLES
                                   + RAND_CYCLES + (64 + RAND_CYCLES) + 6;
    localparam int MARGIN_CYCLES = 50;

    logic      clk;
    logic      rst_n;
    inst_t     inst;
    wb_t       int_wb;
    wb_t       fp_wb;
    ctrl_t     ctrl;
    operands_t operands;
    logic      decode_err;

    word_t  shadow_int [32];
    word_t  shadow_fp [32];
    integer seed = 32'h4acf13ce;
    string  test_name = "reset";
    int     test_errs = 0;
    int     total_errs = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    opcode_t    op;
    reg_sel_t   rs;
    reg_sel_t   rt;
    word_t      exp_reg1;
    word_t      exp_reg2;
    word_t      exp_imm;
    word_t      exp_ofs;
    word_t      exp_fp_reg1;
    word_t      exp_fp_reg2;
    logic       exp_err;
    logic       exp_ctrl_zero;
    logic [8:0] exp_key;
    logic [8:0] act_key;

    decode_stage decode_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .int_wb     (int_wb),
        .fp_wb      (fp_wb),
        .ctrl       (ctrl),
        .operands   (operands),
        .decode_err (decode_err)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic word_t int_read(reg_sel_t sel, wb_t wb, word_t stored);
        if (sel == '0) begin
            return '0;
        end
        return (wb.en && wb.sel == sel) ? wb.data : stored;
    endfunction

    function automatic word_t fp_read(reg_sel_t sel, wb_t wb, word_t stored);
        return (wb.en && wb.sel == sel) ? wb.data : stored;
    endfunction

    function automatic logic is_legal(opcode_t code);
        case (code)
            OP_ADD, OP_ADDI, OP_ORI, OP_LD, OP_ST, OP_J, OP_JAL,
            OP_FADD, OP_FLD, OP_FST, OP_FCVTI, OP_FMOVI, OP_NOP: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Key bits from j_type down to reg_write in the order of act_key
    function automatic logic [8:0] expected_key(opcode_t code);
        case (code)
            OP_ADD, OP_ADDI:    return 9'b00_0_000001;
            OP_J:               return 9'b01_0_000000;
            OP_JAL:             return 9'b10_0_000001;
            OP_ORI:             return 9'b00_0_100001;
            OP_LD:              return 9'b00_0_000101;
            OP_ST:              return 9'b00_0_000010;
            OP_FADD:            return 9'b00_1_000000;
            OP_FLD:             return 9'b00_1_001100;
            OP_FST:             return 9'b00_0_001010;
            OP_FCVTI, OP_FMOVI: return 9'b00_1_010000;
            default:            return 9'b00_0_000000;
        endcase
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                shadow_int[i] <= '0;
                shadow_fp[i]  <= '0;
            end
        end else begin
            if (int_wb.en && int_wb.sel != '0) begin
                shadow_int[int_wb.sel] <= int_wb.data;
            end
            if (fp_wb.en) begin
                shadow_fp[fp_wb.sel] <= fp_wb.data;
            end
        end
    end

    assign op = inst[31:26];
    assign rs = inst[25:21];
    assign rt = inst[20:16];

    always_comb begin
        exp_reg1    = int_read(rs, int_wb, shadow_int[rs]);
        exp_fp_reg2 = fp_read(rt, fp_wb, shadow_fp[rt]);
        // FP loads and stores move the FP rt value into reg2
        if (op == OP_FLD || op == OP_FST) begin
            exp_reg2 = exp_fp_reg2;
        end else begin
            exp_reg2 = int_read(rt, int_wb, shadow_int[rt]);
        end
        if (op == OP_FCVTI || op == OP_FMOVI) begin
            exp_fp_reg1 = exp_reg1;
        end else begin
            exp_fp_reg1 = fp_read(rs, fp_wb, shadow_fp[rs]);
        end
        exp_imm = (op == OP_ORI) ? {16'h0000, inst[15:0]} : {{16{inst[15]}}, inst[15:0]};
        exp_ofs = {{6{inst[25]}}, inst[25:0]};
        exp_err = !is_legal(op) || (int_wb.en && int_wb.sel == '0);
        exp_ctrl_zero = !is_legal(op) || (op == OP_NOP);
        exp_key = expected_key(op);
        act_key = {ctrl.j_type, ctrl.fp_reg_write, ctrl.xtend_sel, ctrl.fp_int_cvt_reg[0],
                   ctrl.fp_inst & (ctrl.mem_read | ctrl.mem_write),
                   ctrl.mem_read, ctrl.mem_write, ctrl.reg_write};
    end

    //////////////////////////////////////////////////////////////////////
    // Checkers
    //////////////////////////////////////////////////////////////////////

    task automatic report_value(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        test_errs++;
        $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
    endtask

    a_reg1: assert property (@(posedge clk) disable iff (!rst_n) operands.reg1 == exp_reg1)
        else report_value("reg1", exp_reg1, operands.reg1);
    a_reg2: assert property (@(posedge clk) disable iff (!rst_n) operands.reg2 == exp_reg2)
        else report_value("reg2", exp_reg2, operands.reg2);
    a_fp_reg1: assert property (@(posedge clk) disable iff (!rst_n)
                                operands.fp_reg1 == exp_fp_reg1)
        else report_value("fp_reg1", exp_fp_reg1, operands.fp_reg1);
    a_fp_reg2: assert property (@(posedge clk) disable iff (!rst_n)
                                operands.fp_reg2 == exp_fp_reg2)
        else report_value("fp_reg2", exp_fp_reg2, operands.fp_reg2);
    a_imm: assert property (@(posedge clk) disable iff (!rst_n) operands.imm == exp_imm)
        else report_value("imm", exp_imm, operands.imm);
    a_ofs: assert property (@(posedge clk) disable iff (!rst_n) operands.ofs == exp_ofs)
        else report_value("ofs", exp_ofs, operands.ofs);
    a_err: assert property (@(posedge clk) disable iff (!rst_n) decode_err == exp_err)
        else report_value("decode_err", 32'(exp_err), 32'(decode_err));
    a_ctrl_key: assert property (@(posedge clk) disable iff (!rst_n) act_key == exp_key)
        else report_value("ctrl fields", 32'(exp_key), 32'(act_key));
    a_ctrl_zero: assert property (@(posedge clk) disable iff (!rst_n)
                                  exp_ctrl_zero |-> ctrl == '0)
        else report_value("ctrl", 32'h0, 32'(ctrl));

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic reg_sel_t rand_sel();
        return reg_sel_t'(rand_word());
    endfunction

    function automatic inst_t make_inst(opcode_t code, reg_sel_t s, reg_sel_t t,
                                        logic [15:0] imm);
        return {code, s, t, imm};
    endfunction

    function automatic wb_t make_wb(logic en, reg_sel_t sel, word_t data);
        wb_t wb;
        wb.en   = en;
        wb.sel  = sel;
        wb.data = data;
        return wb;
    endfunction

    task automatic drive_cycle(input inst_t i, input wb_t iw, input wb_t fw);
        @(negedge clk);
        inst   = i;
        int_wb = iw;
        fp_wb  = fw;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    // Lets the last drive get checked and then idles the inputs
    task automatic finish_test();
        @(negedge clk);
        tests_run++;
        total_errs += test_errs;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("%-16s %s (%0d errors)", test_name, (test_errs == 0) ? "pass" : "FAIL",
                 test_errs);
        inst   = make_inst(OP_NOP, '0, '0, '0);
        int_wb = '0;
        fp_wb  = '0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    opcode_t legal_ops [13] = '{OP_ADD, OP_ADDI, OP_ORI, OP_LD, OP_ST, OP_J, OP_JAL,
                                OP_FADD, OP_FLD, OP_FST, OP_FCVTI, OP_FMOVI, OP_NOP};

    initial begin
        reg_sel_t s;
        reg_sel_t t;
        reg_sel_t w;
        inst_t    word;

        rst_n  = 1'b0;
        inst   = make_inst(OP_NOP, '0, '0, '0);
        int_wb = '0;
        fp_wb  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        start_test("reset_values");
        for (int i = 0; i < 32; i++) begin
            drive_cycle(make_inst(OP_ADD, reg_sel_t'(i), reg_sel_t'(31 - i), '0), '0, '0);
        end
        finish_test();

        start_test("write_read");
        for (int i = 0; i < RAND_CYCLES; i++) begin
            w = rand_sel();
            if (w == '0) begin
                w = 5'd1;
            end
            drive_cycle(make_inst(OP_ADD, rand_sel(), rand_sel(), '0),
                        make_wb(rand_word() % 4 != 0, w, rand_word()),
                        make_wb(rand_word() % 4 != 0, rand_sel(), rand_word()));
        end
        for (int i = 0; i < 32; i++) begin
            drive_cycle(make_inst(OP_ADD, reg_sel_t'(i), reg_sel_t'(31 - i), '0), '0, '0);
        end
        finish_test();

        start_test("bypass");
        for (int i = 0; i < 32; i++) begin
            s = rand_sel();
            t = (i % 4 == 0) ? s : rand_sel();
            drive_cycle(make_inst(OP_ADD, s, t, '0),
                        make_wb(1'b1, i[0] ? s : t, rand_word()),
                        make_wb(1'b1, i[1] ? s : t, rand_word()));
        end
        finish_test();

        start_test("immediates");
        for (int i = 0; i < RAND_CYCLES; i++) begin
            word = rand_word();
            word[31:26] = i[0] ? OP_ORI : OP_ADDI;
            drive_cycle(word, '0, '0);
        end
        finish_test();

        start_test("steering");
        for (int i = 0; i < RAND_CYCLES; i++) begin
            w = rand_sel();
            if (w == '0) begin
                w = 5'd2;
            end
            drive_cycle(make_inst(legal_ops[i % 13], rand_sel(), rand_sel(), 16'(rand_word())),
                        make_wb(i[0], w, rand_word()),
                        make_wb(i[1], rand_sel(), rand_word()));
        end
        finish_test();

        start_test("decode_errors");
        // Every opcode once with integer register 0 written on odd passes
        for (int i = 0; i < 64; i++) begin
            w = rand_sel();
            if (w == '0) begin
                w = 5'd3;
            end
            drive_cycle(make_inst(opcode_t'(i), rand_sel(), rand_sel(), 16'(rand_word())),
                        make_wb(1'b1, i[0] ? 5'd0 : w, rand_word()),
                        make_wb(1'b1, rand_sel(), rand_word()));
        end
        for (int i = 0; i < RAND_CYCLES; i++) begin
            drive_cycle(rand_word(),
                        make_wb(rand_word() % 2 != 0, (i % 4 == 0) ? 5'd0 : rand_sel(),
                                rand_word()),
                        make_wb(rand_word() % 2 != 0, rand_sel(), rand_word()));
        end
        finish_test();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
                 total_errs);
        if (total_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * 20);
        $display("Watchdog expired before the tests completed");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hdl
hdl/wi23_defs.sv
hdl/rf.sv
hdl/inst_ctrl.sv
hdl/decode.sv
hdl/decode_stage.sv
test/decode_stage_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator and run it.
# The run fails when the log holds the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=decode_stage_sim

verilator --binary --timing --assert -j 0 \
    -f list.f \
    --top-module decode_stage_tb \
    -o "$SIM" > "$LOG" 2>&1 \
    && ./obj_dir/"$SIM" >> "$LOG" 2>&1 \
    || echo "Something failed" >> "$LOG"

cat "$LOG"

grep -q "Something failed" "$LOG" && exit 1 || exit 0
